/* include/pi_defines.svh */
/* shared-memory port sizing
   master count, word width and slave memory depth */

`ifndef PI_DEFINES_SVH
`define PI_DEFINES_SVH

// number of bus masters sharing the slave, must be at least 2
// each master owns exactly one request slot and one response slot
`define PI_MASTERCOUNT 3

// data word width in bits, a multiple of 8 so that byte lanes divide it
`define PI_ARCHBITSZ 32

// number of words in the slave memory
// the address type is sized from this value
`define PI_MEMDEPTH 64

`endif

/* rtl/pi_pkg.sv */
/* shared-memory port types
   op codes, word, address, byte select and the queued request */

`include "pi_defines.svh"

package pi_pkg;

	// the op encoding follows the reference bridge
	// bit 0 means the op writes, bit 1 means it returns a word
	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WROP = 2'b01,
		PI_RDOP = 2'b10,
		PI_RWOP = 2'b11
	} pi_op_t;

	typedef logic [`PI_ARCHBITSZ-1:0] pi_word_t;

	// one select bit per byte lane of the word
	typedef logic [`PI_ARCHBITSZ/8-1:0] pi_sel_t;

	typedef logic [$clog2(`PI_MEMDEPTH)-1:0] pi_addr_t;

	// indexes a master, a request slot or a response slot
	typedef logic [$clog2(`PI_MASTERCOUNT)-1:0] pi_midx_t;

	// payload of one request slot, captured as a whole from one master
	typedef struct packed {
		pi_op_t   op;
		pi_addr_t addr;
		pi_word_t data;
		pi_sel_t  sel;
	} pi_req_t;

endpackage

/* rtl/pi_req_if.sv */
/* request store connection
   carries the slot write, the slot read and their indexes */

`timescale 1ns/1ps

interface pi_req_if;
	import pi_pkg::*;

	// write side, one slot is filled per accepted master request
	logic     we;
	pi_midx_t widx;
	pi_req_t  wdata;

	// read side, the slot at ridx is the oldest queued request
	pi_midx_t ridx;
	pi_req_t  rdata;

	// the controller steers both indexes and sees the head of the queue
	// wdata is muxed from the master inputs outside the controller
	modport ctrl (
		output we,
		output widx,
		output ridx,
		input  rdata
	);

	modport store (
		input  we,
		input  widx,
		input  wdata,
		input  ridx,
		output rdata
	);

endinterface

/* rtl/pi_slot_ram.sv */
/* per-master slot store
   one register per master, holding a request or a response word */

`timescale 1ns/1ps
`include "pi_defines.svh"

module pi_slot_ram #(
	parameter type payload_t = pi_pkg::pi_word_t
) (
	input  logic             m_clk_i,
	input  logic             we_i,
	input  pi_pkg::pi_midx_t widx_i,
	input  payload_t         wdata_i,
	input  pi_pkg::pi_midx_t ridx_i,
	output payload_t         rdata_o,
	output payload_t         slot_o [`PI_MASTERCOUNT]
);

	// slot k belongs to master k for the whole run
	payload_t slot_q [`PI_MASTERCOUNT];

	// payload only, a slot is meaningful once the controller has filled it
	always_ff @(posedge m_clk_i) begin
		if (we_i)
			slot_q[widx_i] <= wdata_i;
	end

	// asynchronous read so the head entry reaches the slave in the same cycle
	assign rdata_o = slot_q[ridx_i];

	// all slots in parallel, the response store drives the master data outputs
	assign slot_o = slot_q;

endmodule

/* rtl/pi_ram_slave.sv */
/* byte-lane memory slave
   single-port RAM with wait states from stall_i and a registered read port */

`timescale 1ns/1ps
`include "pi_defines.svh"

module pi_ram_slave (
	input  logic             m_clk_i,
	input  logic             rst_i,
	input  logic             stall_i,
	input  pi_pkg::pi_op_t   op_i,
	input  pi_pkg::pi_addr_t addr_i,
	input  pi_pkg::pi_word_t data_i,
	input  pi_pkg::pi_sel_t  sel_i,
	output pi_pkg::pi_word_t data_o,
	output logic             rdy_o
);
	import pi_pkg::*;

	localparam int NB = $bits(pi_sel_t);

	pi_word_t mem_q [`PI_MEMDEPTH];

	logic acc;
	logic is_wr;
	logic is_rd;

	// a stalled slave takes nothing, so the op on the inputs is held for it
	assign rdy_o = !stall_i;
	assign acc   = !stall_i && !rst_i;

	// read-write does both, the read sees the word from before the write
	assign is_wr = (op_i == PI_WROP) || (op_i == PI_RWOP);
	assign is_rd = (op_i == PI_RDOP) || (op_i == PI_RWOP);

	always_ff @(posedge m_clk_i) begin
		if (acc) begin
			// only the selected byte lanes are updated
			if (is_wr) begin
				for (int b = 0; b < NB; b++) begin
					if (sel_i[b])
						mem_q[addr_i][8*b +: 8] <= data_i[8*b +: 8];
				end
			end
			// data_o keeps the last read word until another read is accepted
			if (is_rd)
				data_o <= mem_q[addr_i];
		end
	end

	// the word at a no-op address is the same one edge later
	a_noop_keeps_mem: assert property (@(posedge m_clk_i) disable iff (rst_i)
		(op_i == PI_NOOP) |=> (mem_q[$past(addr_i)] == $past(mem_q[addr_i])));

endmodule

/* rtl/pi_queue_ctrl.sv */
/* request queue controller
   rotates the write index over the masters, applies the ready rule
   and issues the oldest queued request to the slave */

`timescale 1ns/1ps
`include "pi_defines.svh"

module pi_queue_ctrl (
	input  logic                       m_clk_i,
	input  logic                       rst_i,
	input  pi_pkg::pi_op_t             m_op_i [`PI_MASTERCOUNT],
	input  logic                       s_rdy_i,
	pi_req_if.ctrl                     rq,
	output logic [`PI_MASTERCOUNT-1:0] m_rdy_o,
	output pi_pkg::pi_op_t             s_op_o,
	output logic                       rsp_we_o,
	output pi_pkg::pi_midx_t           rsp_idx_o
);
	import pi_pkg::*;

	localparam int NM = `PI_MASTERCOUNT;
	localparam int IW = $bits(pi_midx_t);

	// usage counts from 0 to NM, so it needs one bit above the index
	typedef logic [IW:0] cnt_t;

	localparam cnt_t     NCNT = cnt_t'(NM);
	localparam pi_midx_t LAST = pi_midx_t'(NM - 1);

	// the wrap bits tell a full queue from an empty one when the indexes match
	pi_midx_t w_idx;
	logic     w_wrap;
	pi_midx_t r_idx;
	logic     r_wrap;

	// slot of the entry most recently handed to the slave
	// its read word shows up on the slave data port one ready edge later
	pi_midx_t prev_r_idx;

	// low through reset and for the first edge after it
	logic run;

	// the op held in each slot is copied here for the near-full check
	pi_op_t op_sh [NM];

	cnt_t usage;
	logic empty;
	logic full;
	logic near_full;
	logic we;
	logic accept;

	// queue usage follows from the two indexes modulo NM, which need not be a power of two
	always_comb begin
		if (w_wrap == r_wrap)
			usage = {1'b0, w_idx} - {1'b0, r_idx};
		else
			usage = NCNT - {1'b0, r_idx} + {1'b0, w_idx};
	end

	assign empty     = (usage == '0);
	assign full      = (usage == NCNT);
	assign near_full = (usage == NCNT - 1'b1);

	// only the master under the write index may be ready
	// with one free slot left, that slot was just issued, so when it held a read
	// its word has not reached the response slot yet and the master must wait
	for (genvar k = 0; k < NM; k++) begin : g_rdy
		assign m_rdy_o[k] = run && (w_idx == pi_midx_t'(k)) && !full &&
			!(near_full && (op_sh[k] == PI_RDOP || op_sh[k] == PI_RWOP));
	end

	// at most one bit is high, so any bit set means slot w_idx is written
	assign we = |m_rdy_o;

	// the slave takes the head entry whenever it is not stalled
	assign accept = s_rdy_i && !empty;

	assign rq.we   = we;
	assign rq.widx = w_idx;
	assign rq.ridx = r_idx;

	// an empty queue shows a no-op so the stale head slot has no effect
	assign s_op_o = empty ? PI_NOOP : rq.rdata.op;

	// every ready edge copies the slave read port into the slot issued before,
	// the slave holds its word between reads, so repeated copies are harmless
	assign rsp_we_o  = s_rdy_i;
	assign rsp_idx_o = prev_r_idx;

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			run        <= 1'b0;
			w_idx      <= '0;
			w_wrap     <= 1'b0;
			r_idx      <= '0;
			r_wrap     <= 1'b0;
			prev_r_idx <= '0;
			for (int k = 0; k < NM; k++)
				op_sh[k] <= PI_NOOP;
		end else begin
			run <= 1'b1;
			// a no-op is queued like any other op and still takes its turn
			if (we) begin
				op_sh[w_idx] <= m_op_i[w_idx];
				w_idx        <= (w_idx == LAST) ? '0 : w_idx + 1'b1;
				w_wrap       <= w_wrap ^ (w_idx == LAST);
			end
			if (accept) begin
				prev_r_idx <= r_idx;
				r_idx      <= (r_idx == LAST) ? '0 : r_idx + 1'b1;
				r_wrap     <= r_wrap ^ (r_idx == LAST);
			end
		end
	end

	// the rotation hands the bus to one master at a time
	a_one_ready: assert property (@(posedge m_clk_i) disable iff (rst_i)
		$onehot0(m_rdy_o));

	// a full queue must never overwrite a slot that the slave has not taken
	// matching indexes with different wrap bits mean every slot is still queued
	a_no_write_full: assert property (@(posedge m_clk_i) disable iff (rst_i)
		(w_idx == r_idx && w_wrap != r_wrap) |-> !rq.we);

endmodule

/* rtl/pi_mem_subsys.sv */
/* shared-memory port top level
   queues requests from several masters in turn into one memory slave */

`timescale 1ns/1ps
`include "pi_defines.svh"

module pi_mem_subsys (
	input  logic                                                    m_clk_i,
	input  logic                                                    rst_i,
	input  logic                                                    stall_i,
	input  logic [$bits(pi_pkg::pi_op_t)*`PI_MASTERCOUNT-1:0]       m_op_i,
	input  logic [$bits(pi_pkg::pi_addr_t)*`PI_MASTERCOUNT-1:0]     m_addr_i,
	input  logic [`PI_ARCHBITSZ*`PI_MASTERCOUNT-1:0]                m_data_i,
	input  logic [(`PI_ARCHBITSZ/8)*`PI_MASTERCOUNT-1:0]            m_sel_i,
	output logic [`PI_ARCHBITSZ*`PI_MASTERCOUNT-1:0]                m_data_o,
	output logic [`PI_MASTERCOUNT-1:0]                              m_rdy_o
);
	import pi_pkg::*;

	localparam int NM = `PI_MASTERCOUNT;
	localparam int OW = $bits(pi_op_t);
	localparam int AW = $bits(pi_addr_t);
	localparam int WW = $bits(pi_word_t);
	localparam int SW = $bits(pi_sel_t);

	pi_op_t   m_op     [NM];
	pi_req_t  m_req    [NM];
	pi_word_t rsp_slot [NM];

	pi_op_t   s_op;
	pi_word_t s_data;
	logic     s_rdy;
	logic     rsp_we;
	pi_midx_t rsp_idx;

	pi_req_if rq ();

	// master k sits at slice k of every flat bus
	for (genvar k = 0; k < NM; k++) begin : g_split
		assign m_op[k]  = pi_op_t'(m_op_i[OW*k +: OW]);
		assign m_req[k] = '{
			op:   m_op[k],
			addr: m_addr_i[AW*k +: AW],
			data: m_data_i[WW*k +: WW],
			sel:  m_sel_i[SW*k +: SW]
		};
		assign m_data_o[WW*k +: WW] = rsp_slot[k];
	end

	// the slot being written always takes the inputs of the master it belongs to
	assign rq.wdata = m_req[rq.widx];

	pi_queue_ctrl u_ctrl (
		.m_clk_i   (m_clk_i),
		.rst_i     (rst_i),
		.m_op_i    (m_op),
		.s_rdy_i   (s_rdy),
		.rq        (rq.ctrl),
		.m_rdy_o   (m_rdy_o),
		.s_op_o    (s_op),
		.rsp_we_o  (rsp_we),
		.rsp_idx_o (rsp_idx)
	);

	pi_slot_ram #(.payload_t(pi_req_t)) u_req_slots (
		.m_clk_i (m_clk_i),
		.we_i    (rq.we),
		.widx_i  (rq.widx),
		.wdata_i (rq.wdata),
		.ridx_i  (rq.ridx),
		.rdata_o (rq.rdata),
		.slot_o  ()
	);

	// response slots are only read in parallel, through the master data outputs
	pi_slot_ram #(.payload_t(pi_word_t)) u_rsp_slots (
		.m_clk_i (m_clk_i),
		.we_i    (rsp_we),
		.widx_i  (rsp_idx),
		.wdata_i (s_data),
		.ridx_i  (rsp_idx),
		.rdata_o (),
		.slot_o  (rsp_slot)
	);

	pi_ram_slave u_slave (
		.m_clk_i (m_clk_i),
		.rst_i   (rst_i),
		.stall_i (stall_i),
		.op_i    (s_op),
		.addr_i  (rq.rdata.addr),
		.data_i  (rq.rdata.data),
		.sel_i   (rq.rdata.sel),
		.data_o  (s_data),
		.rdy_o   (s_rdy)
	);

endmodule

/* testbench/tb_clkgen.sv */
/* testbench clock and reset
   free-running clock and a synchronous reset held for a few cycles */

`timescale 1ns/1ps

module tb_clkgen #(
	parameter int period_ns  = 20,
	parameter int rst_cycles = 4
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(period_ns / 2) clk_o = ~clk_o;
	end

	// reset drops on a falling edge, so the next rising edge sees it low
	initial begin
		rst_o = 1'b1;
		repeat (rst_cycles) @(posedge clk_o);
		@(negedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

/* testbench/tb_pi_mem_subsys.sv */
/* testbench for the shared-memory port
   applies a table of master requests and checks ready order and read data */

`timescale 1ns/1ps
`include "pi_defines.svh"

module tb_pi_mem_subsys;
	import pi_pkg::*;

	localparam int NM = `PI_MASTERCOUNT;
	localparam int OW = $bits(pi_op_t);
	localparam int AW = $bits(pi_addr_t);
	localparam int WW = $bits(pi_word_t);
	localparam int SW = $bits(pi_sel_t);

	// stall is the number of cycles stall_i stays high from this entry on
	typedef struct {
		string    name;
		int       master;
		pi_op_t   op;
		pi_addr_t addr;
		pi_word_t data;
		pi_sel_t  sel;
		int       stall;
	} entry_t;

	logic                clk;
	logic                rst;
	logic                stall;
	logic [OW*NM-1:0]    m_op;
	logic [AW*NM-1:0]    m_addr;
	logic [WW*NM-1:0]    m_data;
	logic [SW*NM-1:0]    m_sel;
	logic [WW*NM-1:0]    m_data_out;
	logic [NM-1:0]       m_rdy;

	entry_t   tab [$];
	pi_word_t ref_mem [`PI_MEMDEPTH];
	logic     pending [NM];
	pi_word_t exp_rd [NM];
	string    exp_name [NM];
	integer   seed;
	logic     built;

	tb_clkgen #(.period_ns(20), .rst_cycles(4)) u_clkgen (
		.clk_o (clk),
		.rst_o (rst)
	);

	pi_mem_subsys uut (
		.m_clk_i  (clk),
		.rst_i    (rst),
		.stall_i  (stall),
		.m_op_i   (m_op),
		.m_addr_i (m_addr),
		.m_data_i (m_data),
		.m_sel_i  (m_sel),
		.m_data_o (m_data_out),
		.m_rdy_o  (m_rdy)
	);

	// byte lane k of the result comes from the new word when sel bit k is set
	function automatic pi_word_t merge_bytes(pi_word_t old_w, pi_word_t new_w, pi_sel_t sel);
		pi_word_t res;
		res = old_w;
		for (int b = 0; b < SW; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic any_pending();
		logic p;
		p = 1'b0;
		for (int k = 0; k < NM; k++)
			p = p | pending[k];
		return p;
	endfunction

	task automatic add_entry(string name, int master, pi_op_t op, pi_addr_t addr,
			pi_word_t data, pi_sel_t sel, int stall_cycles);
		entry_t e;
		e.name   = name;
		e.master = master;
		e.op     = op;
		e.addr   = addr;
		e.data   = data;
		e.sel    = sel;
		e.stall  = stall_cycles;
		tab.push_back(e);
	endtask

	task automatic check_word(string name, pi_word_t exp, pi_word_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_rdy(string name, logic [NM-1:0] exp, logic [NM-1:0] act);
		if (act !== exp) begin
			$display("error %s expected %b actual %b", name, exp, act);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// the master on turn gets the entry, every other master sees a no-op
	task automatic drive_master(int k, entry_t e);
		pi_word_t old_w;
		m_op   = '0;
		m_addr = '0;
		m_data = '0;
		m_sel  = '0;
		m_op[OW*k +: OW]   = e.op;
		m_addr[AW*k +: AW] = e.addr;
		m_data[WW*k +: WW] = e.data;
		m_sel[SW*k +: SW]  = e.sel;
		// the queue keeps capture order, so the reference memory is updated now
		old_w = ref_mem[e.addr];
		if (e.op == PI_RDOP || e.op == PI_RWOP) begin
			pending[k]  = 1'b1;
			exp_rd[k]   = old_w;
			exp_name[k] = e.name;
		end
		if (e.op == PI_WROP || e.op == PI_RWOP)
			ref_mem[e.addr] = merge_bytes(old_w, e.data, e.sel);
	endtask

	task automatic build_table();
		// every word gets a known value before any read
		for (int a = 0; a < `PI_MEMDEPTH; a++)
			add_entry("fill", a % NM, PI_WROP, pi_addr_t'(a), pi_word_t'($random(seed)), '1, 0);
		add_entry("wr_full", 0, PI_WROP, 6'd5, 32'hcafef00d, 4'b1111, 0);
		add_entry("rd_after_wr", 1, PI_RDOP, 6'd5, '0, '0, 0);
		add_entry("byte_wr_lo", 2, PI_WROP, 6'd5, 32'h11223344, 4'b0001, 0);
		add_entry("byte_wr_mid", 0, PI_WROP, 6'd5, 32'h55667788, 4'b0110, 0);
		add_entry("rd_bytes", 1, PI_RDOP, 6'd5, '0, '0, 0);
		add_entry("rw_old", 2, PI_RWOP, 6'd9, 32'h0badbeef, 4'b1100, 0);
		add_entry("rd_merged", 0, PI_RDOP, 6'd9, '0, '0, 0);
		// stall over several rotations while the queue fills
		add_entry("stall_rd_a", 1, PI_RDOP, 6'd5, '0, '0, 12);
		add_entry("stall_wr", 2, PI_WROP, 6'd20, 32'ha5a5a5a5, 4'b1111, 0);
		add_entry("stall_rd_b", 0, PI_RDOP, 6'd20, '0, '0, 0);
		add_entry("stall_rw", 1, PI_RWOP, 6'd20, 32'h0f0f0f0f, 4'b0101, 0);
		add_entry("stall_rd_c", 2, PI_RDOP, 6'd20, '0, '0, 0);
		// no-ops between a read and its result
		add_entry("noop_rd", 0, PI_RDOP, 6'd30, '0, '0, 0);
		add_entry("noop_a", 1, PI_NOOP, 6'd30, 32'hffffffff, 4'b1111, 0);
		add_entry("noop_b", 2, PI_NOOP, 6'd31, 32'hffffffff, 4'b1111, 0);
		add_entry("noop_chk", 0, PI_RDOP, 6'd30, '0, '0, 0);
		for (int i = 0; i < 8; i++)
			add_entry("rand", i % NM, pi_op_t'($random(seed)), pi_addr_t'($random(seed)),
				pi_word_t'($random(seed)), pi_sel_t'($random(seed)), 0);
	endtask

	initial begin
		int            idx;
		int            turn;
		int            stall_cnt;
		int            stall_edges;
		logic [NM-1:0] r;
		entry_t        idle;
		m_op   = '0;
		m_addr = '0;
		m_data = '0;
		m_sel  = '0;
		stall  = 1'b0;
		built  = 1'b0;
		seed   = 32'hddf8;
		for (int k = 0; k < NM; k++) begin
			pending[k] = 1'b0;
			exp_rd[k]  = '0;
		end
		idle.op = PI_NOOP;
		idle.addr = '0;
		idle.data = '0;
		idle.sel = '0;
		build_table();
		built = 1'b1;
		// no master may be ready while reset is high
		@(negedge clk);
		while (rst) begin
			check_rdy("reset", '0, m_rdy);
			@(negedge clk);
		end
		// this falling edge is the first one with reset low, so it is sampled too
		idx         = 0;
		turn        = 0;
		stall_cnt   = 0;
		stall_edges = 0;
		while (idx < tab.size() || any_pending() || stall_cnt > 0) begin
			r = m_rdy;
			stall_edges = stall ? stall_edges + 1 : 0;
			// after more stalled edges than slots the queue cannot take anything
			if (stall_edges > NM)
				check_rdy("stall_full", '0, r);
			if (r != '0) begin
				check_rdy("rotation", NM'(1) << turn, r);
				if (pending[turn]) begin
					check_word(exp_name[turn], exp_rd[turn], m_data_out[WW*turn +: WW]);
					pending[turn] = 1'b0;
				end
				if (idx < tab.size() && tab[idx].master == turn) begin
					drive_master(turn, tab[idx]);
					if (tab[idx].stall > 0)
						stall_cnt = tab[idx].stall;
					idx++;
				end else begin
					drive_master(turn, idle);
				end
				turn = (turn + 1) % NM;
			end
			stall = (stall_cnt > 0);
			if (stall_cnt > 0)
				stall_cnt--;
			@(negedge clk);
		end
		$display("** PASS **");
		$finish;
	end

	// every entry has a generous budget of 40 cycles
	initial begin
		int cycles;
		wait (built);
		cycles = tab.size() * 40;
		repeat (cycles) @(posedge clk);
		$display("timeout: the table did not complete in %0d cycles", cycles);
		$display("** FAIL **");
		$fatal(1);
	end

endmodule

/* verilog.f */
+incdir+include
rtl/pi_pkg.sv
rtl/pi_req_if.sv
rtl/pi_slot_ram.sv
rtl/pi_ram_slave.sv
rtl/pi_queue_ctrl.sv
rtl/pi_mem_subsys.sv
testbench/tb_clkgen.sv
testbench/tb_pi_mem_subsys.sv

/* Makefile */
# Verilator build for the shared-memory port and its testbench

VERILATOR ?= verilator
FLIST     ?= verilog.f
TOP       ?= tb_pi_mem_subsys
RTL_TOP   ?= pi_mem_subsys
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation gave no verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
